/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_apb_shared_mem
	./obj_dir/Vtb_apb_shared_mem > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* apb_cmd_bridge.sv */
module apb_cmd_bridge (
    input  logic                               aclk,
    input  logic                               aresetn,

    input  logic                               i_psel,
    input  logic                               i_penable,
    input  logic [apb_mem_pkg::addr_w-1:0]     i_paddr,
    input  logic                               i_pwrite,
    input  logic [apb_mem_pkg::data_w-1:0]     i_pwdata,
    input  logic [apb_mem_pkg::strb_w-1:0]     i_pstrb,
    input  logic [2:0]                         i_pprot,
    output logic [apb_mem_pkg::data_w-1:0]     o_prdata,
    output logic                               o_pready,
    output logic                               o_pslverr,

    output logic                               o_cmd_valid,
    input  logic                               i_cmd_ready,
    output apb_mem_pkg::cmd_pkt_t              o_cmd,

    input  logic                               i_rsp_valid,
    output logic                               o_rsp_ready,
    input  apb_mem_pkg::rsp_pkt_t              i_rsp
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        WAIT_RSP = 2'd1,
        COMPLETE = 2'd2
    } state_t;

    state_t                r_state;
    state_t                w_next_state;

    apb_mem_pkg::cmd_pkt_t w_cmd;
    logic                  w_cmd_load;
    logic                  w_cmd_in_ready;

    apb_mem_pkg::rsp_pkt_t w_rsp;
    logic                  w_rsp_valid;
    logic                  w_rsp_ready;

    assign w_cmd.write = i_pwrite;
    assign w_cmd.prot  = i_pprot;
    assign w_cmd.strb  = i_pstrb;
    assign w_cmd.addr  = i_paddr;
    assign w_cmd.wdata = i_pwdata;

    // One command per access phase, only from IDLE
    assign w_cmd_load = (r_state == IDLE) & i_psel & i_penable;

    skid_buffer #(
        .WIDTH   ($bits(apb_mem_pkg::cmd_pkt_t))
    ) u_cmd_skid (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_valid (w_cmd_load),
        .o_ready (w_cmd_in_ready),
        .i_data  (w_cmd),
        .o_valid (o_cmd_valid),
        .i_ready (i_cmd_ready),
        .o_data  (o_cmd)
    );

    skid_buffer #(
        .WIDTH   ($bits(apb_mem_pkg::rsp_pkt_t))
    ) u_rsp_skid (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_valid (i_rsp_valid),
        .o_ready (o_rsp_ready),
        .i_data  (i_rsp),
        .o_valid (w_rsp_valid),
        .i_ready (w_rsp_ready),
        .o_data  (w_rsp)
    );

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    always_comb begin
        w_next_state = r_state;
        case (r_state)
            IDLE: begin
                if (w_cmd_load & w_cmd_in_ready) begin
                    w_next_state = WAIT_RSP;
                end
            end
            WAIT_RSP: begin
                if (w_rsp_valid) begin
                    w_next_state = COMPLETE;
                end
            end
            COMPLETE: w_next_state = IDLE;       // Response popped this cycle
            default:  w_next_state = IDLE;
        endcase
    end

    assign w_rsp_ready = (r_state == COMPLETE);
    assign o_pready    = (r_state == COMPLETE);
    assign o_prdata    = o_pready ? w_rsp.rdata : '0;
    assign o_pslverr   = o_pready & w_rsp.slverr;

endmodule : apb_cmd_bridge

/* apb_mem_pkg.sv */
package apb_mem_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // Request from a bridge toward the memory target
    typedef struct packed {
        logic              write;
        logic [2:0]        prot;   // Only bit 0 is looked at
        logic [strb_w-1:0] strb;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } cmd_pkt_t;

    typedef struct packed {
        logic              slverr;
        logic [data_w-1:0] rdata;  // Zero on writes and errors
    } rsp_pkt_t;

endpackage : apb_mem_pkg

/* apb_shared_mem_top.sv */
module apb_shared_mem_top #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                           aclk,
    input  logic                           aresetn,

    input  logic                           i_a_psel,
    input  logic                           i_a_penable,
    input  logic [apb_mem_pkg::addr_w-1:0] i_a_paddr,
    input  logic                           i_a_pwrite,
    input  logic [apb_mem_pkg::data_w-1:0] i_a_pwdata,
    input  logic [apb_mem_pkg::strb_w-1:0] i_a_pstrb,
    input  logic [2:0]                     i_a_pprot,
    output logic [apb_mem_pkg::data_w-1:0] o_a_prdata,
    output logic                           o_a_pready,
    output logic                           o_a_pslverr,

    input  logic                           i_b_psel,
    input  logic                           i_b_penable,
    input  logic [apb_mem_pkg::addr_w-1:0] i_b_paddr,
    input  logic                           i_b_pwrite,
    input  logic [apb_mem_pkg::data_w-1:0] i_b_pwdata,
    input  logic [apb_mem_pkg::strb_w-1:0] i_b_pstrb,
    input  logic [2:0]                     i_b_pprot,
    output logic [apb_mem_pkg::data_w-1:0] o_b_prdata,
    output logic                           o_b_pready,
    output logic                           o_b_pslverr
);

    logic                  a_cmd_valid;
    logic                  a_cmd_ready;
    apb_mem_pkg::cmd_pkt_t a_cmd;
    logic                  a_rsp_valid;
    logic                  a_rsp_ready;
    apb_mem_pkg::rsp_pkt_t a_rsp;

    logic                  b_cmd_valid;
    logic                  b_cmd_ready;
    apb_mem_pkg::cmd_pkt_t b_cmd;
    logic                  b_rsp_valid;
    logic                  b_rsp_ready;
    apb_mem_pkg::rsp_pkt_t b_rsp;

    logic                  t_cmd_valid;   // Arbiter to target
    logic                  t_cmd_ready;
    apb_mem_pkg::cmd_pkt_t t_cmd;
    logic                  t_rsp_valid;
    logic                  t_rsp_ready;
    apb_mem_pkg::rsp_pkt_t t_rsp;

    apb_cmd_bridge u_bridge_a (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_psel      (i_a_psel),
        .i_penable   (i_a_penable),
        .i_paddr     (i_a_paddr),
        .i_pwrite    (i_a_pwrite),
        .i_pwdata    (i_a_pwdata),
        .i_pstrb     (i_a_pstrb),
        .i_pprot     (i_a_pprot),
        .o_prdata    (o_a_prdata),
        .o_pready    (o_a_pready),
        .o_pslverr   (o_a_pslverr),
        .o_cmd_valid (a_cmd_valid),
        .i_cmd_ready (a_cmd_ready),
        .o_cmd       (a_cmd),
        .i_rsp_valid (a_rsp_valid),
        .o_rsp_ready (a_rsp_ready),
        .i_rsp       (a_rsp)
    );

    apb_cmd_bridge u_bridge_b (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_psel      (i_b_psel),
        .i_penable   (i_b_penable),
        .i_paddr     (i_b_paddr),
        .i_pwrite    (i_b_pwrite),
        .i_pwdata    (i_b_pwdata),
        .i_pstrb     (i_b_pstrb),
        .i_pprot     (i_b_pprot),
        .o_prdata    (o_b_prdata),
        .o_pready    (o_b_pready),
        .o_pslverr   (o_b_pslverr),
        .o_cmd_valid (b_cmd_valid),
        .i_cmd_ready (b_cmd_ready),
        .o_cmd       (b_cmd),
        .i_rsp_valid (b_rsp_valid),
        .o_rsp_ready (b_rsp_ready),
        .i_rsp       (b_rsp)
    );

    cmd_arbiter u_arbiter (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_a_cmd_valid (a_cmd_valid),
        .o_a_cmd_ready (a_cmd_ready),
        .i_a_cmd       (a_cmd),
        .o_a_rsp_valid (a_rsp_valid),
        .i_a_rsp_ready (a_rsp_ready),
        .o_a_rsp       (a_rsp),
        .i_b_cmd_valid (b_cmd_valid),
        .o_b_cmd_ready (b_cmd_ready),
        .i_b_cmd       (b_cmd),
        .o_b_rsp_valid (b_rsp_valid),
        .i_b_rsp_ready (b_rsp_ready),
        .o_b_rsp       (b_rsp),
        .o_cmd_valid   (t_cmd_valid),
        .i_cmd_ready   (t_cmd_ready),
        .o_cmd         (t_cmd),
        .i_rsp_valid   (t_rsp_valid),
        .o_rsp_ready   (t_rsp_ready),
        .i_rsp         (t_rsp)
    );

    reg_mem_target #(
        .MEM_DEPTH   (MEM_DEPTH)
    ) u_target (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (t_cmd_valid),
        .o_cmd_ready (t_cmd_ready),
        .i_cmd       (t_cmd),
        .o_rsp_valid (t_rsp_valid),
        .i_rsp_ready (t_rsp_ready),
        .o_rsp       (t_rsp)
    );

endmodule : apb_shared_mem_top

/* cmd_arbiter.sv */
module cmd_arbiter (
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  i_a_cmd_valid,
    output logic                  o_a_cmd_ready,
    input  apb_mem_pkg::cmd_pkt_t i_a_cmd,
    output logic                  o_a_rsp_valid,
    input  logic                  i_a_rsp_ready,
    output apb_mem_pkg::rsp_pkt_t o_a_rsp,

    input  logic                  i_b_cmd_valid,
    output logic                  o_b_cmd_ready,
    input  apb_mem_pkg::cmd_pkt_t i_b_cmd,
    output logic                  o_b_rsp_valid,
    input  logic                  i_b_rsp_ready,
    output apb_mem_pkg::rsp_pkt_t o_b_rsp,

    output logic                  o_cmd_valid,
    input  logic                  i_cmd_ready,
    output apb_mem_pkg::cmd_pkt_t o_cmd,
    input  logic                  i_rsp_valid,
    output logic                  o_rsp_ready,
    input  apb_mem_pkg::rsp_pkt_t i_rsp
);

    logic r_busy;      // Grant held until the response handshake
    logic r_owner_b;
    logic r_last_b;    // Round-robin history
    logic w_sel_b;
    logic w_cmd_fire;
    logic w_rsp_fire;

    // B wins alone, or on a tie when A had the last grant
    assign w_sel_b = i_b_cmd_valid & (~i_a_cmd_valid | ~r_last_b);

    assign o_cmd_valid   = ~r_busy & (i_a_cmd_valid | i_b_cmd_valid);
    assign o_cmd         = w_sel_b ? i_b_cmd : i_a_cmd;
    assign o_a_cmd_ready = ~r_busy & ~w_sel_b & i_cmd_ready;
    assign o_b_cmd_ready = ~r_busy & w_sel_b & i_cmd_ready;

    assign w_cmd_fire = o_cmd_valid & i_cmd_ready;

    // Response goes back to the owner only
    assign o_a_rsp_valid = r_busy & ~r_owner_b & i_rsp_valid;
    assign o_b_rsp_valid = r_busy & r_owner_b & i_rsp_valid;
    assign o_a_rsp       = i_rsp;
    assign o_b_rsp       = i_rsp;
    assign o_rsp_ready   = r_busy & (r_owner_b ? i_b_rsp_ready : i_a_rsp_ready);

    assign w_rsp_fire = i_rsp_valid & o_rsp_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_busy    <= 1'b0;
            r_owner_b <= 1'b0;
            r_last_b  <= 1'b0;
        end else if (w_cmd_fire) begin
            r_busy    <= 1'b1;
            r_owner_b <= w_sel_b;
            r_last_b  <= w_sel_b;
        end else if (w_rsp_fire) begin
            r_busy    <= 1'b0;                 // Next grant from the following cycle
        end
    end

endmodule : cmd_arbiter

/* files.f */
apb_mem_pkg.sv
skid_buffer.sv
apb_cmd_bridge.sv
cmd_arbiter.sv
reg_mem_target.sv
apb_shared_mem_top.sv
tb_apb_shared_mem_sva.sv
tb_apb_shared_mem.sv

/* reg_mem_target.sv */
module reg_mem_target #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  i_cmd_valid,
    output logic                  o_cmd_ready,
    input  apb_mem_pkg::cmd_pkt_t i_cmd,

    output logic                  o_rsp_valid,
    input  logic                  i_rsp_ready,
    output apb_mem_pkg::rsp_pkt_t o_rsp
);

    localparam int WORD_W = apb_mem_pkg::addr_w - 2;
    localparam int IDX_W  = $clog2(MEM_DEPTH);
    localparam logic [WORD_W-1:0] LIMIT     = WORD_W'(MEM_DEPTH);
    localparam logic [WORD_W-1:0] PROT_BASE = WORD_W'(MEM_DEPTH - MEM_DEPTH / 4);

    logic [apb_mem_pkg::data_w-1:0] mem [MEM_DEPTH];

    logic                  r_rsp_valid;
    apb_mem_pkg::rsp_pkt_t r_rsp;
    logic [WORD_W-1:0]     w_word;
    logic [IDX_W-1:0]      w_idx;
    logic                  w_accept;
    logic                  w_range_err;
    logic                  w_prot_err;
    logic                  w_err;
    logic                  w_wr_en;

    assign o_cmd_ready = ~r_rsp_valid;      // One response held at a time
    assign w_accept    = i_cmd_valid & ~r_rsp_valid;

    assign w_word      = i_cmd.addr[apb_mem_pkg::addr_w-1:2];
    assign w_idx       = w_word[IDX_W-1:0];
    assign w_range_err = (w_word >= LIMIT);

    // Top quarter needs privileged writes, reads are open
    assign w_prot_err = i_cmd.write & ~i_cmd.prot[0] & (w_word >= PROT_BASE);
    assign w_err      = w_range_err | w_prot_err;
    assign w_wr_en    = w_accept & i_cmd.write & ~w_err;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_rsp_valid <= 1'b0;
        end else if (w_accept) begin
            r_rsp_valid <= 1'b1;
        end else if (i_rsp_ready) begin
            r_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (w_accept) begin
            r_rsp.slverr <= w_err;
            r_rsp.rdata  <= (i_cmd.write | w_err) ? '0 : mem[w_idx];
        end
    end

    // Byte lanes
    always_ff @(posedge aclk) begin
        for (int i = 0; i < apb_mem_pkg::strb_w; i++) begin
            if (w_wr_en & i_cmd.strb[i]) begin
                mem[w_idx][8*i +: 8] <= i_cmd.wdata[8*i +: 8];
            end
        end
    end

    assign o_rsp_valid = r_rsp_valid;
    assign o_rsp       = r_rsp;

endmodule : reg_mem_target

/* skid_buffer.sv */
module skid_buffer #(
    parameter int WIDTH = 32
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             i_valid,
    output logic             o_ready,
    input  logic [WIDTH-1:0] i_data,
    output logic             o_valid,
    input  logic             i_ready,
    output logic [WIDTH-1:0] o_data
);

    logic             r_out_valid;
    logic [WIDTH-1:0] r_out_data;
    logic             r_skid_valid;
    logic [WIDTH-1:0] r_skid_data;
    logic             w_out_load;
    logic             w_in_fire;

    assign w_out_load = i_ready | ~r_out_valid;  // Output stage can take a packet
    assign w_in_fire  = i_valid & ~r_skid_valid;

    assign o_ready = ~r_skid_valid;               // Registered ready
    assign o_valid = r_out_valid;
    assign o_data  = r_out_data;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_out_valid  <= 1'b0;
            r_skid_valid <= 1'b0;
        end else if (w_out_load) begin
            r_out_valid  <= r_skid_valid | w_in_fire;
            r_skid_valid <= 1'b0;
        end else if (w_in_fire) begin
            r_skid_valid <= 1'b1;                  // Output stalled, park it
        end
    end

    // Skid entry drains first so order is kept
    always_ff @(posedge aclk) begin
        if (w_out_load) begin
            if (r_skid_valid) begin
                r_out_data <= r_skid_data;
            end else if (w_in_fire) begin
                r_out_data <= i_data;
            end
        end else if (w_in_fire) begin
            r_skid_data <= i_data;
        end
    end

endmodule : skid_buffer

/* tb_apb_shared_mem.sv */
module tb_apb_shared_mem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int rounds = 20;
    // About 140 transfers at under 20 cycles each, plus reset and margin
    localparam int max_cycles = 4000;

    typedef struct packed {
        logic                           psel;
        logic                           penable;
        logic [apb_mem_pkg::addr_w-1:0] paddr;
        logic                           pwrite;
        logic [apb_mem_pkg::data_w-1:0] pwdata;
        logic [apb_mem_pkg::strb_w-1:0] pstrb;
        logic [2:0]                     pprot;
    } apb_req_t;

    logic                           aclk;
    logic                           aresetn;
    apb_req_t                       a_req;
    apb_req_t                       b_req;
    logic [apb_mem_pkg::data_w-1:0] a_prdata;
    logic [apb_mem_pkg::data_w-1:0] b_prdata;
    logic                           a_pready;
    logic                           b_pready;
    logic                           a_pslverr;
    logic                           b_pslverr;

    int                             err_cnt;
    int                             cycle_cnt;
    int unsigned                    depth;
    logic [apb_mem_pkg::data_w-1:0] model_mem [int unsigned];  // Words written so far

    apb_shared_mem_top DUT (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_a_psel    (a_req.psel),
        .i_a_penable (a_req.penable),
        .i_a_paddr   (a_req.paddr),
        .i_a_pwrite  (a_req.pwrite),
        .i_a_pwdata  (a_req.pwdata),
        .i_a_pstrb   (a_req.pstrb),
        .i_a_pprot   (a_req.pprot),
        .o_a_prdata  (a_prdata),
        .o_a_pready  (a_pready),
        .o_a_pslverr (a_pslverr),
        .i_b_psel    (b_req.psel),
        .i_b_penable (b_req.penable),
        .i_b_paddr   (b_req.paddr),
        .i_b_pwrite  (b_req.pwrite),
        .i_b_pwdata  (b_req.pwdata),
        .i_b_pstrb   (b_req.pstrb),
        .i_b_pprot   (b_req.pprot),
        .o_b_prdata  (b_prdata),
        .o_b_pready  (b_pready),
        .o_b_pslverr (b_pslverr)
    );

    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Run timed out after %0d cycles with a transfer still open", cycle_cnt);
            $display("%0d errors", err_cnt);
            $display("sim failed");
            $finish;
        end
    end

    // Expected response by the memory rules, and the model update
    function automatic apb_mem_pkg::rsp_pkt_t model_access(
        input logic                           write,
        input int unsigned                    word,
        input logic [apb_mem_pkg::data_w-1:0] wdata,
        input logic [apb_mem_pkg::strb_w-1:0] strb,
        input logic [2:0]                     prot
    );
        apb_mem_pkg::rsp_pkt_t          rsp;
        logic [apb_mem_pkg::data_w-1:0] merged;
        rsp = '0;
        if (word >= depth || (write && !prot[0] && word >= depth - depth / 4)) begin
            rsp.slverr = 1'b1;                  // Out of range or protected quarter
        end else if (write) begin
            merged = model_mem.exists(word) ? model_mem[word] : '0;
            for (int i = 0; i < apb_mem_pkg::strb_w; i++) begin
                if (strb[i]) begin
                    merged[8*i +: 8] = wdata[8*i +: 8];
                end
            end
            model_mem[word] = merged;
        end else begin
            rsp.rdata = model_mem[word];
        end
        return rsp;
    endfunction

    task automatic check_rsp(input string name, input int unsigned word,
                             input apb_mem_pkg::rsp_pkt_t got, input apb_mem_pkg::rsp_pkt_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s word %0h: got slverr %h rdata %h, expected slverr %h rdata %h",
                     name, word, got.slverr, got.rdata, exp.slverr, exp.rdata);
        end
    endtask

    task automatic check_word(input string name, input logic [apb_mem_pkg::data_w-1:0] got,
                              input logic [apb_mem_pkg::data_w-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic drive_port(input bit port_b, input apb_req_t req);
        if (port_b) begin
            b_req = req;
        end else begin
            a_req = req;
        end
    endtask

    // Setup, access, wait for pready, hold through the completion edge
    task automatic apb_access(input bit port_b, input logic write, input int unsigned word,
                              input logic [apb_mem_pkg::data_w-1:0] wdata,
                              input logic [apb_mem_pkg::strb_w-1:0] strb,
                              input logic [2:0] prot, output apb_mem_pkg::rsp_pkt_t rsp);
        apb_req_t req;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.paddr   = word << 2;
        req.pwrite  = write;
        req.pwdata  = wdata;
        req.pstrb   = strb;
        req.pprot   = prot;
        @(negedge aclk);
        drive_port(port_b, req);
        @(negedge aclk);
        req.penable = 1'b1;
        drive_port(port_b, req);
        @(negedge aclk);
        while ((port_b ? b_pready : a_pready) !== 1'b1) begin
            @(negedge aclk);
        end
        rsp.slverr = port_b ? b_pslverr : a_pslverr;
        rsp.rdata  = port_b ? b_prdata : a_prdata;
        @(negedge aclk);
        drive_port(port_b, '0);
    endtask

    task automatic apb_write(input bit port_b, input int unsigned word,
                             input logic [apb_mem_pkg::data_w-1:0] data,
                             input logic [apb_mem_pkg::strb_w-1:0] strb, input logic [2:0] prot);
        apb_mem_pkg::rsp_pkt_t exp;
        apb_mem_pkg::rsp_pkt_t got;
        exp = model_access(1'b1, word, data, strb, prot);
        apb_access(port_b, 1'b1, word, data, strb, prot, got);
        check_rsp(port_b ? "o_b_pslverr/o_b_prdata" : "o_a_pslverr/o_a_prdata", word, got, exp);
    endtask

    task automatic apb_read(input bit port_b, input int unsigned word, input logic [2:0] prot,
                            output logic [apb_mem_pkg::data_w-1:0] data);
        apb_mem_pkg::rsp_pkt_t exp;
        apb_mem_pkg::rsp_pkt_t got;
        exp = model_access(1'b0, word, '0, '0, prot);
        apb_access(port_b, 1'b0, word, '0, '0, prot, got);
        check_rsp(port_b ? "o_b_pslverr/o_b_prdata" : "o_a_pslverr/o_a_prdata", word, got, exp);
        data = got.rdata;
    endtask

    task automatic test_write_read();
        int unsigned                    word;
        logic [apb_mem_pkg::data_w-1:0] data;
        logic [apb_mem_pkg::data_w-1:0] rd;
        for (int i = 0; i < 16; i++) begin
            word = $urandom % (depth - depth / 4);
            data = $urandom;
            apb_write(1'b0, word, data, 4'hf, 3'b000);
            apb_read(1'b0, word, 3'b000, rd);
            check_word("o_a_prdata", rd, data);
        end
    endtask

    task automatic test_strobes();
        logic [3:0]                     strobes [5] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110};
        int unsigned                    word;
        logic [apb_mem_pkg::data_w-1:0] exp;
        logic [apb_mem_pkg::data_w-1:0] data;
        logic [apb_mem_pkg::data_w-1:0] rd;
        word = $urandom % (depth - depth / 4);
        exp  = $urandom;
        apb_write(1'b0, word, exp, 4'hf, 3'b000);
        foreach (strobes[s]) begin
            data = $urandom;
            apb_write(1'b0, word, data, strobes[s], 3'b000);
            for (int i = 0; i < 4; i++) begin
                if (strobes[s][i]) exp[8*i +: 8] = data[8*i +: 8];
            end
            apb_read(1'b0, word, 3'b000, rd);
            check_word("o_a_prdata", rd, exp);
        end
    endtask

    task automatic test_sharing();
        int unsigned                    word;
        logic [apb_mem_pkg::data_w-1:0] data;
        logic [apb_mem_pkg::data_w-1:0] rd;
        word = $urandom % (depth - depth / 4);
        data = $urandom;
        apb_write(1'b1, word, data, 4'hf, 3'b000);
        apb_read(1'b0, word, 3'b000, rd);
        check_word("o_a_prdata", rd, data);
        word = $urandom % (depth - depth / 4);
        data = $urandom;
        apb_write(1'b0, word, data, 4'hf, 3'b000);
        apb_read(1'b1, word, 3'b000, rd);
        check_word("o_b_prdata", rd, data);
    endtask

    task automatic test_errors();
        int unsigned                    word;
        logic [apb_mem_pkg::data_w-1:0] v1;
        logic [apb_mem_pkg::data_w-1:0] v2;
        logic [apb_mem_pkg::data_w-1:0] rd;
        apb_read(1'b0, depth + 5, 3'b001, rd);
        check_word("o_a_prdata", rd, '0);
        apb_write(1'b1, depth, $urandom, 4'hf, 3'b001);
        word = depth - 1;                       // Protected quarter
        v1   = $urandom;
        v2   = ~v1;
        apb_write(1'b0, word, v1, 4'hf, 3'b001);
        apb_write(1'b0, word, v2, 4'hf, 3'b000);
        apb_read(1'b0, word, 3'b000, rd);
        check_word("o_a_prdata", rd, v1);
        apb_write(1'b1, word, v2, 4'hf, 3'b001);
        apb_read(1'b1, word, 3'b000, rd);
        check_word("o_b_prdata", rd, v2);
    endtask

    task automatic test_contention();
        int unsigned                    wa;
        int unsigned                    wb;
        logic [apb_mem_pkg::data_w-1:0] da;
        logic [apb_mem_pkg::data_w-1:0] db;
        logic [apb_mem_pkg::data_w-1:0] rd;
        logic                           wr_a;
        logic                           wr_b;
        apb_mem_pkg::rsp_pkt_t          exp_a;
        apb_mem_pkg::rsp_pkt_t          exp_b;
        apb_mem_pkg::rsp_pkt_t          got_a;
        apb_mem_pkg::rsp_pkt_t          got_b;
        int unsigned                    used [$];
        for (int r = 0; r < rounds; r++) begin
            wa = $urandom % (depth - depth / 4);
            wb = $urandom % (depth - depth / 4);
            while (wb == wa) begin
                wb = $urandom % (depth - depth / 4);
            end
            da    = $urandom;
            db    = $urandom;
            wr_a  = ($urandom % 2 == 0) || !model_mem.exists(wa);  // Never read an unset word
            wr_b  = ($urandom % 2 == 0) || !model_mem.exists(wb);
            exp_a = model_access(wr_a, wa, da, 4'hf, 3'b000);
            exp_b = model_access(wr_b, wb, db, 4'hf, 3'b000);
            fork
                apb_access(1'b0, wr_a, wa, da, 4'hf, 3'b000, got_a);
                apb_access(1'b1, wr_b, wb, db, 4'hf, 3'b000, got_b);
            join
            check_rsp("o_a_pslverr/o_a_prdata", wa, got_a, exp_a);
            check_rsp("o_b_pslverr/o_b_prdata", wb, got_b, exp_b);
            used.push_back(wa);
            used.push_back(wb);
        end
        foreach (used[i]) begin
            apb_read(i % 2 == 1, used[i], 3'b000, rd);
        end
    endtask

    initial begin
        void'($urandom(32'h292));
        aclk      = 1'b0;
        aresetn   = 1'b0;
        a_req     = '0;
        b_req     = '0;
        err_cnt   = 0;
        cycle_cnt = 0;
        depth     = DUT.MEM_DEPTH;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        test_write_read();
        test_strobes();
        test_sharing();
        test_errors();
        test_contention();

        repeat (4) @(negedge aclk);
        $display("%0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_apb_shared_mem

/* tb_apb_shared_mem_sva.sv */
module apb_shared_mem_sva (
    input logic aclk,
    input logic aresetn,
    input logic i_a_psel,
    input logic i_a_penable,
    input logic i_a_pready,
    input logic i_a_pslverr,
    input logic i_b_psel,
    input logic i_b_penable,
    input logic i_b_pready,
    input logic i_b_pslverr,
    input logic i_a_rsp_valid,
    input logic i_b_rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [4:0] r_since_rst;   // Saturates at 16

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_since_rst <= '0;
        end else if (r_since_rst != 5'd16) begin
            r_since_rst <= r_since_rst + 5'd1;
        end
    end

    a_ready_in_access: assert property (@(posedge aclk) disable iff (!aresetn)
        i_a_pready |-> (i_a_psel && i_a_penable))
        else $error("port A pready outside an access phase");
    b_ready_in_access: assert property (@(posedge aclk) disable iff (!aresetn)
        i_b_pready |-> (i_b_psel && i_b_penable))
        else $error("port B pready outside an access phase");

    a_err_with_ready: assert property (@(posedge aclk) disable iff (!aresetn)
        i_a_pslverr |-> i_a_pready) else $error("port A pslverr without pready");
    b_err_with_ready: assert property (@(posedge aclk) disable iff (!aresetn)
        i_b_pslverr |-> i_b_pready) else $error("port B pslverr without pready");

    // Response goes to one owner only
    rsp_one_owner: assert property (@(posedge aclk) disable iff (!aresetn)
        !(i_a_rsp_valid && i_b_rsp_valid)) else $error("both response valids high");

    a_quiet_after_reset: assert property (@(posedge aclk) disable iff (!aresetn)
        (r_since_rst < 5'd16 && !i_a_psel) |-> !i_a_pready)
        else $error("port A pready after reset without psel");
    b_quiet_after_reset: assert property (@(posedge aclk) disable iff (!aresetn)
        (r_since_rst < 5'd16 && !i_b_psel) |-> !i_b_pready)
        else $error("port B pready after reset without psel");

endmodule : apb_shared_mem_sva

bind apb_shared_mem_top apb_shared_mem_sva u_sva (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_a_psel      (i_a_psel),
    .i_a_penable   (i_a_penable),
    .i_a_pready    (o_a_pready),
    .i_a_pslverr   (o_a_pslverr),
    .i_b_psel      (i_b_psel),
    .i_b_penable   (i_b_penable),
    .i_b_pready    (o_b_pready),
    .i_b_pslverr   (o_b_pslverr),
    .i_a_rsp_valid (a_rsp_valid),
    .i_b_rsp_valid (b_rsp_valid)
);
